//--- hw/e2p_pkg.sv
package e2p_pkg;

    // ----------------------------------------------------------
    // Fixed constants
    // ----------------------------------------------------------
    localparam int DATA_W = 32;
    localparam int IDX_W = 5;

    // Value the EEPROM must return on configuration readback
    localparam logic [DATA_W-1:0] CFG_SIGNATURE = 32'h8765_4321;

    // Configuration attempts in all, the first included
    localparam int MAX_CFG_TRIES = 3;

    // ----------------------------------------------------------
    // Enumerations
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        CFG_WRITE,
        CFG_READBACK,
        WREN,
        WRITE,
        WRDI,
        RDSR,
        READ
    } e2p_op_e;

    typedef enum logic [0:0] {
        HOST_WRITE,
        HOST_READ
    } host_op_e;

    // One state per step of the configuration, write and read sequences
    typedef enum logic [3:0] {
        IDLE,
        CFG_WR,
        CFG_GAP,
        CFG_RB,
        CFG_CHK,
        READY,
        WR_WREN,
        WR_GAP1,
        WR_DATA,
        WR_GAP2,
        WR_WRDI,
        WR_SETTLE,
        RD_RDSR,
        RD_GAP1,
        RD_READ,
        RD_GAP2
    } seq_state_e;

    // ----------------------------------------------------------
    // Bundles between stages
    // ----------------------------------------------------------
    typedef struct packed {
        host_op_e op;
        logic [DATA_W-1:0] data;
    } host_req_t;

    typedef struct packed {
        e2p_op_e op;
        logic [IDX_W-1:0] index;
        logic [DATA_W-1:0] data;
    } e2p_cmd_t;

    typedef struct packed {
        logic valid;
        host_op_e op;
        logic [DATA_W-1:0] data;
    } host_rsp_t;

endpackage

//--- hw/e2p_req_queue.sv
`timescale 1ns/1ps

module e2p_req_queue #(
    parameter int REQ_DEPTH = 2
) (
    input  logic               clk_sys,
    input  logic               rst_sys_n,
    input  e2p_pkg::host_req_t req,
    input  logic               req_valid,
    output e2p_pkg::host_req_t head,
    output logic               head_valid,
    input  logic               pop,
    output logic               credit_return
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    e2p_pkg::host_req_t mem [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             pop_fire;

    // Host credits guarantee a free slot, so every valid request is written
    assign pop_fire   = pop && head_valid;
    assign head_valid = (fill != '0);
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    // ----------------------------------------------------------
    // Pointers and fill count
    // ----------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop_fire})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // One credit back per popped entry, a cycle after the pop
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_fire;
        end
    end

endmodule

//--- hw/e2p_delay_timer.sv
`timescale 1ns/1ps

module e2p_delay_timer #(
    parameter int GAP_CYCLES    = 256,
    parameter int SETTLE_CYCLES = 500
) (
    input  logic clk_sys,
    input  logic rst_sys_n,
    input  logic gap_start,
    input  logic settle_start,
    output logic expired
);

    localparam int MAX_CYCLES = (GAP_CYCLES > SETTLE_CYCLES) ? GAP_CYCLES : SETTLE_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    logic [CNT_W-1:0] load_val;
    logic [CNT_W-1:0] cnt;
    logic             active;

    // Count limit picked by whichever start arrives
    assign load_val = gap_start ? CNT_W'(GAP_CYCLES - 1) : CNT_W'(SETTLE_CYCLES - 1);

    // Expiry lands exactly N cycles after the start pulse
    assign expired = active && (cnt == '0);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (gap_start || settle_start) begin
            cnt    <= load_val;
            active <= 1'b1;
        end else if (active) begin
            if (cnt == '0) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

//--- hw/e2p_sequencer.sv
`timescale 1ns/1ps

module e2p_sequencer #(
    parameter int CON_CNT       = 16,
    parameter int GAP_CYCLES    = 256,
    parameter int SETTLE_CYCLES = 500
) (
    input  logic                         clk_sys,
    input  logic                         rst_sys_n,
    input  logic                         pw_on_en,
    input  e2p_pkg::host_req_t           head,
    input  logic                         head_valid,
    output logic                         pop,
    output e2p_pkg::e2p_cmd_t            cmd,
    output logic                         cmd_start,
    input  logic                         done,
    input  logic [e2p_pkg::DATA_W-1:0]   rd_data,
    output e2p_pkg::host_rsp_t           fin,
    output logic                         cfg_pass,
    output logic                         cfg_fail
);

    localparam int TRY_W = $clog2(e2p_pkg::MAX_CFG_TRIES + 1);

    e2p_pkg::seq_state_e           state;
    e2p_pkg::host_req_t            req_q;
    logic [e2p_pkg::IDX_W-1:0]     cfg_idx;
    logic [TRY_W-1:0]              tries;
    logic                          rb_ok;
    logic [e2p_pkg::DATA_W-1:0]    rd_q;
    logic                          gap_start;
    logic                          settle_start;
    logic                          expired;

    function automatic e2p_pkg::e2p_cmd_t make_cmd(
        input e2p_pkg::e2p_op_e          op,
        input logic [e2p_pkg::IDX_W-1:0]  index,
        input logic [e2p_pkg::DATA_W-1:0] data
    );
        e2p_pkg::e2p_cmd_t c;
        c.op    = op;
        c.index = index;
        c.data  = data;
        return c;
    endfunction

    e2p_delay_timer #(
        .GAP_CYCLES    (GAP_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) e2p_delay_timer_i (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .gap_start    (gap_start),
        .settle_start (settle_start),
        .expired      (expired)
    );

    // Request payload taken at pop, read data taken when READ completes
    always_ff @(posedge clk_sys) begin
        if (pop) begin
            req_q <= head;
        end
        if (state == e2p_pkg::RD_READ && done) begin
            rd_q <= rd_data;
        end
    end

    // ----------------------------------------------------------
    // Main FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state        <= e2p_pkg::IDLE;
            cmd          <= '0;
            cmd_start    <= 1'b0;
            gap_start    <= 1'b0;
            settle_start <= 1'b0;
            pop          <= 1'b0;
            fin          <= '0;
            cfg_pass     <= 1'b0;
            cfg_fail     <= 1'b0;
            cfg_idx      <= '0;
            tries        <= '0;
            rb_ok        <= 1'b0;
        end else begin
            // Single-cycle pulses
            cmd_start    <= 1'b0;
            gap_start    <= 1'b0;
            settle_start <= 1'b0;
            pop          <= 1'b0;
            fin.valid    <= 1'b0;
            cfg_pass     <= 1'b0;
            cfg_fail     <= 1'b0;

            case (state)
                e2p_pkg::IDLE: begin
                    tries   <= '0;
                    cfg_idx <= '0;
                    if (pw_on_en) begin
                        cmd       <= make_cmd(e2p_pkg::CFG_WRITE, '0, '0);
                        cmd_start <= 1'b1;
                        state     <= e2p_pkg::CFG_WR;
                    end
                end
                e2p_pkg::CFG_WR: begin
                    if (done) begin
                        gap_start <= 1'b1;
                        state     <= e2p_pkg::CFG_GAP;
                    end
                end
                e2p_pkg::CFG_GAP: begin
                    if (expired) begin
                        cmd_start <= 1'b1;
                        if (cfg_idx == e2p_pkg::IDX_W'(CON_CNT - 1)) begin
                            cmd   <= make_cmd(e2p_pkg::CFG_READBACK, '0, '0);
                            state <= e2p_pkg::CFG_RB;
                        end else begin
                            cfg_idx <= cfg_idx + 1'b1;
                            cmd     <= make_cmd(e2p_pkg::CFG_WRITE, cfg_idx + 1'b1, '0);
                            state   <= e2p_pkg::CFG_WR;
                        end
                    end
                end
                e2p_pkg::CFG_RB: begin
                    if (done) begin
                        rb_ok <= (rd_data == e2p_pkg::CFG_SIGNATURE);
                        tries <= tries + 1'b1;
                        state <= e2p_pkg::CFG_CHK;
                    end
                end
                e2p_pkg::CFG_CHK: begin
                    if (rb_ok) begin
                        cfg_pass <= 1'b1;
                        state    <= e2p_pkg::READY;
                    end else if (tries == TRY_W'(e2p_pkg::MAX_CFG_TRIES)) begin
                        // Out of attempts, still go ready with the error flagged
                        cfg_fail <= 1'b1;
                        state    <= e2p_pkg::READY;
                    end else begin
                        cfg_idx   <= '0;
                        cmd       <= make_cmd(e2p_pkg::CFG_WRITE, '0, '0);
                        cmd_start <= 1'b1;
                        state     <= e2p_pkg::CFG_WR;
                    end
                end
                e2p_pkg::READY: begin
                    if (head_valid) begin
                        pop       <= 1'b1;
                        cmd_start <= 1'b1;
                        if (head.op == e2p_pkg::HOST_WRITE) begin
                            cmd   <= make_cmd(e2p_pkg::WREN, '0, '0);
                            state <= e2p_pkg::WR_WREN;
                        end else begin
                            cmd   <= make_cmd(e2p_pkg::RDSR, '0, '0);
                            state <= e2p_pkg::RD_RDSR;
                        end
                    end
                end
                // Write: WREN, gap, WRITE, gap, WRDI, settle
                e2p_pkg::WR_WREN: begin
                    if (done) begin
                        gap_start <= 1'b1;
                        state     <= e2p_pkg::WR_GAP1;
                    end
                end
                e2p_pkg::WR_GAP1: begin
                    if (expired) begin
                        cmd       <= make_cmd(e2p_pkg::WRITE, '0, req_q.data);
                        cmd_start <= 1'b1;
                        state     <= e2p_pkg::WR_DATA;
                    end
                end
                e2p_pkg::WR_DATA: begin
                    if (done) begin
                        gap_start <= 1'b1;
                        state     <= e2p_pkg::WR_GAP2;
                    end
                end
                e2p_pkg::WR_GAP2: begin
                    if (expired) begin
                        cmd       <= make_cmd(e2p_pkg::WRDI, '0, '0);
                        cmd_start <= 1'b1;
                        state     <= e2p_pkg::WR_WRDI;
                    end
                end
                e2p_pkg::WR_WRDI: begin
                    if (done) begin
                        settle_start <= 1'b1;
                        state        <= e2p_pkg::WR_SETTLE;
                    end
                end
                e2p_pkg::WR_SETTLE: begin
                    if (expired) begin
                        fin   <= '{valid: 1'b1, op: e2p_pkg::HOST_WRITE, data: req_q.data};
                        state <= e2p_pkg::READY;
                    end
                end
                // Read: RDSR, gap, READ, gap
                e2p_pkg::RD_RDSR: begin
                    if (done) begin
                        gap_start <= 1'b1;
                        state     <= e2p_pkg::RD_GAP1;
                    end
                end
                e2p_pkg::RD_GAP1: begin
                    if (expired) begin
                        cmd       <= make_cmd(e2p_pkg::READ, '0, '0);
                        cmd_start <= 1'b1;
                        state     <= e2p_pkg::RD_READ;
                    end
                end
                e2p_pkg::RD_READ: begin
                    if (done) begin
                        gap_start <= 1'b1;
                        state     <= e2p_pkg::RD_GAP2;
                    end
                end
                e2p_pkg::RD_GAP2: begin
                    if (expired) begin
                        fin   <= '{valid: 1'b1, op: e2p_pkg::HOST_READ, data: rd_q};
                        state <= e2p_pkg::READY;
                    end
                end
                default: begin
                    state <= e2p_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/e2p_rsp_stage.sv
`timescale 1ns/1ps

module e2p_rsp_stage (
    input  logic               clk_sys,
    input  logic               rst_sys_n,
    input  e2p_pkg::host_rsp_t fin,
    input  logic               head_valid,
    input  logic               cfg_pass,
    input  logic               cfg_fail,
    output e2p_pkg::host_rsp_t host_rsp,
    output logic               busy,
    output logic               cfg_done,
    output logic               chip_err
);

    logic                       rsp_valid;
    e2p_pkg::host_op_e          rsp_op;
    logic [e2p_pkg::DATA_W-1:0] rsp_data;
    logic                       in_flight;

    assign host_rsp = '{valid: rsp_valid, op: rsp_op, data: rsp_data};

    // Idle only when configured, nothing queued and nothing in the sequencer
    assign busy = !cfg_done || head_valid || in_flight;

    always_ff @(posedge clk_sys) begin
        if (fin.valid) begin
            rsp_op   <= fin.op;
            rsp_data <= fin.data;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            rsp_valid <= 1'b0;
            in_flight <= 1'b0;
            cfg_done  <= 1'b0;
            chip_err  <= 1'b0;
        end else begin
            rsp_valid <= fin.valid;
            // A queued entry outranks the completion of the one before it
            if (head_valid) begin
                in_flight <= 1'b1;
            end else if (fin.valid) begin
                in_flight <= 1'b0;
            end
            if (cfg_pass || cfg_fail) begin
                cfg_done <= 1'b1;
            end
            if (cfg_fail) begin
                chip_err <= 1'b1;
            end
        end
    end

endmodule

//--- hw/e2p_ctl_top.sv
`timescale 1ns/1ps

module e2p_ctl_top #(
    parameter int CON_CNT       = 16,
    parameter int GAP_CYCLES    = 256,
    parameter int SETTLE_CYCLES = 500,
    parameter int REQ_DEPTH     = 2
) (
    input  logic                       clk_sys,
    input  logic                       rst_sys_n,
    input  logic                       pw_on_en,
    input  e2p_pkg::host_req_t         req,
    input  logic                       req_valid,
    output logic                       credit_return,
    output e2p_pkg::e2p_cmd_t          cmd,
    output logic                       cmd_start,
    input  logic                       done,
    input  logic [e2p_pkg::DATA_W-1:0] rd_data,
    output e2p_pkg::host_rsp_t         host_rsp,
    output logic                       busy,
    output logic                       cfg_done,
    output logic                       chip_err
);

    e2p_pkg::host_req_t head;
    logic               head_valid;
    logic               pop;
    e2p_pkg::host_rsp_t fin;
    logic               cfg_pass;
    logic               cfg_fail;

    // ----------------------------------------------------------
    // Queue, sequencer, response
    // ----------------------------------------------------------
    e2p_req_queue #(
        .REQ_DEPTH (REQ_DEPTH)
    ) e2p_req_queue_i (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .req           (req),
        .req_valid     (req_valid),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .credit_return (credit_return)
    );

    e2p_sequencer #(
        .CON_CNT       (CON_CNT),
        .GAP_CYCLES    (GAP_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) e2p_sequencer_i (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .pw_on_en   (pw_on_en),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .cmd        (cmd),
        .cmd_start  (cmd_start),
        .done       (done),
        .rd_data    (rd_data),
        .fin        (fin),
        .cfg_pass   (cfg_pass),
        .cfg_fail   (cfg_fail)
    );

    e2p_rsp_stage e2p_rsp_stage_i (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .fin        (fin),
        .head_valid (head_valid),
        .cfg_pass   (cfg_pass),
        .cfg_fail   (cfg_fail),
        .host_rsp   (host_rsp),
        .busy       (busy),
        .cfg_done   (cfg_done),
        .chip_err   (chip_err)
    );

endmodule

//--- test/e2p_spi_model.sv
`timescale 1ns/1ps

module e2p_spi_model #(
    parameter int CON_CNT = 16
) (
    input  logic                       clk_sys,
    input  logic                       rst_sys_n,
    input  e2p_pkg::e2p_cmd_t          cmd,
    input  logic                       cmd_start,
    input  logic [2:0]                 lat,
    input  logic [e2p_pkg::DATA_W-1:0] rb_value,
    input  logic [e2p_pkg::DATA_W-1:0] read_value,
    output logic                       done,
    output logic [e2p_pkg::DATA_W-1:0] rd_data,
    output int                         fault_cnt
);

    logic             pending;
    logic [2:0]       wait_q;
    e2p_pkg::e2p_op_e op_q;
    int               next_idx;

    // Faults seen over the whole run
    initial fault_cnt = 0;

    always @(posedge clk_sys or negedge rst_sys_n) begin : engine
        int nfault;
        nfault = 0;
        if (!rst_sys_n) begin
            pending  <= 1'b0;
            wait_q   <= '0;
            op_q     <= e2p_pkg::CFG_WRITE;
            next_idx <= 0;
            done     <= 1'b0;
            rd_data  <= '0;
        end else begin
            done <= 1'b0;
            if (cmd_start) begin
                // One command at a time
                assert (!pending) else begin
                    nfault++;
                    $display("Mismatch at %0t: command started while one is outstanding",
                             $time);
                end
                pending <= 1'b1;
                wait_q  <= lat;
                op_q    <= cmd.op;
                case (cmd.op)
                    e2p_pkg::CFG_WRITE: begin
                        assert (int'(cmd.index) == next_idx) else begin
                            nfault++;
                            $display("Mismatch at %0t: CFG_WRITE index %0d, expected %0d",
                                     $time, cmd.index, next_idx);
                        end
                        next_idx <= next_idx + 1;
                    end
                    e2p_pkg::CFG_READBACK: begin
                        assert (next_idx == CON_CNT) else begin
                            nfault++;
                            $display("Mismatch at %0t: CFG_READBACK after %0d writes",
                                     $time, next_idx);
                        end
                        next_idx <= 0;
                    end
                    default: begin
                    end
                endcase
            end else if (pending) begin
                if (wait_q == '0) begin
                    done    <= 1'b1;
                    pending <= 1'b0;
                    case (op_q)
                        e2p_pkg::CFG_READBACK: rd_data <= rb_value;
                        e2p_pkg::READ:         rd_data <= read_value;
                        default:               rd_data <= '0;
                    endcase
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
            fault_cnt <= fault_cnt + nfault;
        end
    end

endmodule

//--- test/e2p_ctl_tb.sv
`timescale 1ns/1ps

module e2p_ctl_tb;

    localparam int CON_CNT       = 4;
    localparam int GAP_CYCLES    = 8;
    localparam int SETTLE_CYCLES = 20;
    localparam int REQ_DEPTH     = 2;

    // ------------------------------------------------------------
    // Worst-case test lengths in cycles
    // ------------------------------------------------------------
    localparam int CMD_MAX = 12;
    localparam int CFG_LEN = CON_CNT * (CMD_MAX + GAP_CYCLES + 2) + CMD_MAX + 4;
    localparam int WR_LEN  = 3 * CMD_MAX + 2 * GAP_CYCLES + SETTLE_CYCLES + 8;
    localparam int RD_LEN  = 2 * CMD_MAX + 2 * GAP_CYCLES + 8;
    localparam int RUN_LEN = 16 + CFG_LEN * (1 + e2p_pkg::MAX_CFG_TRIES)
                             + 2 * (WR_LEN + RD_LEN);
    localparam int TIMEOUT = 2 * RUN_LEN;

    logic                       clk_sys;
    logic                       rst_sys_n;
    logic                       pw_on_en;
    e2p_pkg::host_req_t         req;
    logic                       req_valid;
    logic                       credit_return;
    e2p_pkg::e2p_cmd_t          cmd;
    logic                       cmd_start;
    logic                       done;
    logic [e2p_pkg::DATA_W-1:0] rd_data;
    e2p_pkg::host_rsp_t         host_rsp;
    logic                       busy;
    logic                       cfg_done;
    logic                       chip_err;

    logic [31:0] rb_value;
    logic [31:0] read_value;
    logic [2:0]  lat;
    logic [31:0] data_next;
    logic        data_init;
    logic [31:0] lfsr_q = 32'h5207;
    int          fault_cnt;
    int          errors;
    int          credits;
    int          credit_cnt;
    int          rsp_pending;
    int          cycles;
    int          tests_run;
    int          tests_failed;

    e2p_pkg::e2p_cmd_t  cmd_log[$];
    e2p_pkg::host_rsp_t rsp_log[$];

    e2p_ctl_top #(
        .CON_CNT       (CON_CNT),
        .GAP_CYCLES    (GAP_CYCLES),
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .REQ_DEPTH     (REQ_DEPTH)
    ) e2p_ctl_top_i (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .pw_on_en      (pw_on_en),
        .req           (req),
        .req_valid     (req_valid),
        .credit_return (credit_return),
        .cmd           (cmd),
        .cmd_start     (cmd_start),
        .done          (done),
        .rd_data       (rd_data),
        .host_rsp      (host_rsp),
        .busy          (busy),
        .cfg_done      (cfg_done),
        .chip_err      (chip_err)
    );

    e2p_spi_model #(
        .CON_CNT (CON_CNT)
    ) e2p_spi_model_i (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .cmd        (cmd),
        .cmd_start  (cmd_start),
        .lat        (lat),
        .rb_value   (rb_value),
        .read_value (read_value),
        .done       (done),
        .rd_data    (rd_data),
        .fault_cnt  (fault_cnt)
    );

    always #5 clk_sys = ~clk_sys;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    // Done latency and write data from one stream
    always @(posedge clk_sys) begin
        if (cmd_start) begin
            lat <= 3'(lfsr_bits(3));
        end
        if (req_valid || !data_init) begin
            data_next <= lfsr_bits(32);
            data_init <= 1'b1;
        end
    end

    // Command and response logs, host credits
    always @(posedge clk_sys) begin : track_host
        int next_credits;
        int next_pending;
        next_credits = credits - int'(req_valid) + int'(credit_return);
        next_pending = rsp_pending + int'(req_valid) - int'(host_rsp.valid);
        if (cmd_start) begin
            cmd_log.push_back(cmd);
        end
        if (host_rsp.valid) begin
            rsp_log.push_back(host_rsp);
        end
        if (credit_return) begin
            credit_cnt <= credit_cnt + 1;
        end
        credits     <= next_credits;
        rsp_pending <= next_pending;
        check(next_credits >= 0 && next_credits <= REQ_DEPTH, "host credit count out of range");
        check(next_pending >= 0, "host response without an outstanding request");
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic clear_logs();
        @(negedge clk_sys);
        cmd_log.delete();
        rsp_log.delete();
        credit_cnt = 0;
    endtask

    task automatic apply_reset(input logic [31:0] rb);
        @(posedge clk_sys);
        rst_sys_n <= 1'b0;
        rb_value  <= rb;
        repeat (4) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
    endtask

    task automatic send_req(input e2p_pkg::host_op_e op, input logic [31:0] data);
        while (credits == 0) @(posedge clk_sys);
        req       <= '{op: op, data: data};
        req_valid <= 1'b1;
        @(posedge clk_sys);
        req_valid <= 1'b0;
    endtask

    task automatic wait_cfg_done();
        @(posedge clk_sys);
        while (!cfg_done) @(posedge clk_sys);
    endtask

    // Polls the response log at the falling edge until n responses are in
    task automatic wait_responses(input int n);
        @(negedge clk_sys);
        while (rsp_log.size() < n) @(negedge clk_sys);
    endtask

    task automatic end_test(input string name, input int err_before);
        int n;
        n = errors + fault_cnt - err_before;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name, (n == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        int          err0;
        int          n_rb;
        logic [31:0] wdata;
        logic [31:0] rdata;
        clk_sys      = 1'b0;
        rst_sys_n    = 1'b0;
        pw_on_en     = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        rb_value     = e2p_pkg::CFG_SIGNATURE;
        read_value   = '0;
        lat          = 3'd2;
        data_init    = 1'b0;
        errors       = 0;
        credits      = REQ_DEPTH;
        credit_cnt   = 0;
        rsp_pending  = 0;
        cycles       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // ------------------------------------------------------------
        // Configuration passes
        // ------------------------------------------------------------
        err0 = errors + fault_cnt;
        repeat (4) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
        pw_on_en  <= 1'b1;
        wait_cfg_done();
        check(!busy, "busy still high after configuration");
        check(!chip_err, "chip_err set on a good readback");
        @(negedge clk_sys);
        check(cmd_log.size() == CON_CNT + 1, "wrong configuration command count");
        for (int i = 0; i < CON_CNT; i++) begin
            check(cmd_log[i].op == e2p_pkg::CFG_WRITE && int'(cmd_log[i].index) == i,
                  "CFG_WRITE out of order");
        end
        check(cmd_log[CON_CNT].op == e2p_pkg::CFG_READBACK, "no CFG_READBACK after writes");
        end_test("config pass", err0);

        // ------------------------------------------------------------
        // Every readback wrong
        // ------------------------------------------------------------
        err0 = errors + fault_cnt;
        clear_logs();
        apply_reset(~e2p_pkg::CFG_SIGNATURE);
        wait_cfg_done();
        check(chip_err, "chip_err low after failed configuration");
        @(negedge clk_sys);
        n_rb = 0;
        foreach (cmd_log[i]) begin
            if (cmd_log[i].op == e2p_pkg::CFG_READBACK) begin
                n_rb++;
            end
        end
        check(n_rb == e2p_pkg::MAX_CFG_TRIES, "wrong number of readback attempts");
        end_test("config retry", err0);

        // ------------------------------------------------------------
        // Host write
        // ------------------------------------------------------------
        err0 = errors + fault_cnt;
        clear_logs();
        @(posedge clk_sys);
        wdata = data_next;
        send_req(e2p_pkg::HOST_WRITE, wdata);
        wait_responses(1);
        check(cmd_log.size() == 3, "wrong write command count");
        check(cmd_log[0].op == e2p_pkg::WREN, "write does not start with WREN");
        check(cmd_log[1].op == e2p_pkg::WRITE && cmd_log[1].data == wdata,
              "WRITE missing or carries wrong data");
        check(cmd_log[2].op == e2p_pkg::WRDI, "write does not end with WRDI");
        check(rsp_log[0].op == e2p_pkg::HOST_WRITE, "write response is not HOST_WRITE");
        end_test("write", err0);

        // ------------------------------------------------------------
        // Host read
        // ------------------------------------------------------------
        err0 = errors + fault_cnt;
        clear_logs();
        @(posedge clk_sys);
        rdata = data_next;
        read_value <= rdata;
        send_req(e2p_pkg::HOST_READ, '0);
        wait_responses(1);
        check(cmd_log.size() == 2, "wrong read command count");
        check(cmd_log[0].op == e2p_pkg::RDSR, "read does not start with RDSR");
        check(cmd_log[1].op == e2p_pkg::READ, "READ does not follow RDSR");
        check(rsp_log[0].op == e2p_pkg::HOST_READ && rsp_log[0].data == rdata,
              "read response data differs from READ data");
        end_test("read", err0);

        // ------------------------------------------------------------
        // Two requests back to back
        // ------------------------------------------------------------
        err0 = errors + fault_cnt;
        clear_logs();
        @(posedge clk_sys);
        check(credits == REQ_DEPTH, "host does not hold all credits");
        wdata = data_next;
        rdata = ~data_next;
        read_value <= rdata;
        send_req(e2p_pkg::HOST_WRITE, wdata);
        send_req(e2p_pkg::HOST_READ, '0);
        wait_responses(2);
        check(credit_cnt == 2, "not both credits returned");
        check(rsp_log[0].op == e2p_pkg::HOST_WRITE, "first response is not the write");
        check(rsp_log[1].op == e2p_pkg::HOST_READ && rsp_log[1].data == rdata,
              "second response is not the read");
        end_test("back to back", err0);

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors + fault_cnt);
        if (errors + fault_cnt == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/e2p_pkg.sv
hw/e2p_req_queue.sv
hw/e2p_delay_timer.sv
hw/e2p_sequencer.sv
hw/e2p_rsp_stage.sv
hw/e2p_ctl_top.sv
test/e2p_spi_model.sv
test/e2p_ctl_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module e2p_ctl_tb -f all.f -o e2p_sim \
    && ./obj_dir/e2p_sim | tee /dev/stderr | grep -qx "Regression passed" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

exit 0
